// File: rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// integer register and address width
`define RV32I_XLEN 32

// one enable per byte of a data word
`define RV32I_BE_WIDTH 4

`endif

// File: rv32i_types.sv
`include "rv32i_settings.svh"

package rv32i_types;

  // ------------------------------------------------------------
  // data words
  // ------------------------------------------------------------
  typedef logic [`RV32I_XLEN-1:0] rv32i_word;
  typedef logic [`RV32I_BE_WIDTH-1:0] byte_enable;

  // ------------------------------------------------------------
  // alu operation codes
  // ------------------------------------------------------------
  typedef logic [2:0] alu_op;

  localparam alu_op alu_add = 3'b000;
  localparam alu_op alu_sll = 3'b001;
  localparam alu_op alu_sra = 3'b010;
  localparam alu_op alu_sub = 3'b011;
  localparam alu_op alu_xor = 3'b100;
  localparam alu_op alu_srl = 3'b101;
  localparam alu_op alu_or  = 3'b110;
  localparam alu_op alu_and = 3'b111;

  // ------------------------------------------------------------
  // branch compare codes, same as branch funct3
  // ------------------------------------------------------------
  typedef logic [2:0] cmp_op;

  localparam cmp_op cmp_beq  = 3'b000;
  localparam cmp_op cmp_bne  = 3'b001;
  localparam cmp_op cmp_blt  = 3'b100;
  localparam cmp_op cmp_bge  = 3'b101;
  localparam cmp_op cmp_bltu = 3'b110;
  localparam cmp_op cmp_bgeu = 3'b111;

  // memory access width, stores share the encoding
  typedef logic [2:0] load_funct3;

  localparam load_funct3 ld_lb  = 3'b000;
  localparam load_funct3 ld_lh  = 3'b001;
  localparam load_funct3 ld_lw  = 3'b010;
  localparam load_funct3 ld_lbu = 3'b100;
  localparam load_funct3 ld_lhu = 3'b101;

  // ------------------------------------------------------------
  // operand mux selects
  // ------------------------------------------------------------
  typedef logic       alumux1_sel;
  typedef logic [2:0] alumux2_sel;
  typedef logic       cmpmux_sel;

  localparam alumux1_sel sel1_rs1 = 1'b0;
  localparam alumux1_sel sel1_pc  = 1'b1;

  localparam alumux2_sel sel2_i_imm = 3'd0;
  localparam alumux2_sel sel2_u_imm = 3'd1;
  localparam alumux2_sel sel2_b_imm = 3'd2;
  localparam alumux2_sel sel2_s_imm = 3'd3;
  localparam alumux2_sel sel2_j_imm = 3'd4;
  localparam alumux2_sel sel2_rs2   = 3'd5;

  localparam cmpmux_sel selc_rs2   = 1'b0;
  localparam cmpmux_sel selc_i_imm = 1'b1;

endpackage

// File: alu.sv
module alu (
  input  rv32i_types::alu_op     aluop,
  input  rv32i_types::rv32i_word a,
  input  rv32i_types::rv32i_word b,
  output rv32i_types::rv32i_word f
);

  import rv32i_types::*;

  // shift amount is the low five bits of b
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    unique case (aluop)
      alu_add: begin
        f = a + b;
      end
      alu_sll: begin
        f = a << shamt;
      end
      alu_sra: begin
        // sign bit of a fills from the top
        f = rv32i_word'($signed(a) >>> shamt);
      end
      alu_sub: begin
        f = a - b;
      end
      alu_xor: begin
        f = a ^ b;
      end
      alu_srl: begin
        f = a >> shamt;
      end
      alu_or: begin
        f = a | b;
      end
      alu_and: begin
        f = a & b;
      end
      default: begin
        f = a + b;
      end
    endcase
  end

endmodule

// File: cmp.sv
module cmp (
  input  rv32i_types::cmp_op     cmpop,
  input  rv32i_types::rv32i_word rs1,
  input  rv32i_types::rv32i_word cmp_in,
  output logic                   br_en
);

  import rv32i_types::*;

  always_comb begin
    case (cmpop)
      cmp_beq:  br_en = (rs1 == cmp_in);
      cmp_bne:  br_en = (rs1 != cmp_in);
      // signed forms
      cmp_blt:  br_en = ($signed(rs1) < $signed(cmp_in));
      cmp_bge:  br_en = ($signed(rs1) >= $signed(cmp_in));
      // unsigned forms
      cmp_bltu: br_en = (rs1 < cmp_in);
      cmp_bgeu: br_en = (rs1 >= cmp_in);
      // codes 010 and 011 are not branches
      default:  br_en = 1'b0;
    endcase
  end

endmodule

// File: operand_select.sv
module operand_select (
  input  rv32i_types::rv32i_word   instruction,
  input  rv32i_types::rv32i_word   pc,
  input  rv32i_types::rv32i_word   rs1,
  input  rv32i_types::rv32i_word   rs2,
  input  rv32i_types::alumux1_sel  alumux1,
  input  rv32i_types::alumux2_sel  alumux2,
  input  rv32i_types::cmpmux_sel   cmpmux,
  output rv32i_types::rv32i_word   alu_in_1,
  output rv32i_types::rv32i_word   alu_in_2,
  output rv32i_types::rv32i_word   cmp_in
);

  import rv32i_types::*;

  rv32i_word i_imm;
  rv32i_word s_imm;
  rv32i_word b_imm;
  rv32i_word u_imm;
  rv32i_word j_imm;

  // ------------------------------------------------------------
  // immediates, all sign extended from instruction bit 31
  // ------------------------------------------------------------
  assign i_imm = {{21{instruction[31]}}, instruction[30:20]};

  assign s_imm = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};

  // branch offset, bit 0 always clear
  assign b_imm = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                  instruction[11:8], 1'b0};

  // upper 20 bits, low 12 zero
  assign u_imm = {instruction[31:12], 12'h000};

  // jal offset
  assign j_imm = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                  instruction[30:21], 1'b0};

  // ------------------------------------------------------------
  // operand muxes
  // ------------------------------------------------------------
  always_comb begin
    case (alumux1)
      sel1_pc: alu_in_1 = pc;
      default: alu_in_1 = rs1;
    endcase
  end

  always_comb begin
    case (alumux2)
      sel2_i_imm: alu_in_2 = i_imm;
      sel2_u_imm: alu_in_2 = u_imm;
      sel2_b_imm: alu_in_2 = b_imm;
      sel2_s_imm: alu_in_2 = s_imm;
      sel2_j_imm: alu_in_2 = j_imm;
      sel2_rs2:   alu_in_2 = rs2;
      // unused selects fall back to the register operand
      default:    alu_in_2 = rs2;
    endcase
  end

  // slti-style compares take the i immediate
  always_comb begin
    case (cmpmux)
      selc_i_imm: cmp_in = i_imm;
      default:    cmp_in = rs2;
    endcase
  end

endmodule

// File: instruction_execute.sv
module instruction_execute (
  input  logic                     clk,
  input  logic                     rst,
  input  rv32i_types::rv32i_word   pc,
  input  rv32i_types::rv32i_word   instruction,
  input  rv32i_types::rv32i_word   alu_in_1,
  input  rv32i_types::rv32i_word   alu_in_2,
  input  rv32i_types::rv32i_word   rs1,
  input  rv32i_types::rv32i_word   rs2,
  input  rv32i_types::rv32i_word   cmp_in,
  input  rv32i_types::alu_op       aluop,
  input  rv32i_types::cmp_op       cmpop,
  input  logic                     mem_read,
  input  logic                     mem_write,
  input  logic                     regfile_we,
  output rv32i_types::rv32i_word   pc_out,
  output rv32i_types::rv32i_word   instruction_out,
  output rv32i_types::rv32i_word   alu_out,
  output rv32i_types::rv32i_word   rs2_out,
  output logic                     br_en_out,
  output rv32i_types::byte_enable  mem_byte_enable_out,
  output logic                     mem_read_out,
  output logic                     mem_write_out,
  output logic                     regfile_we_out
);

  import rv32i_types::*;

  rv32i_word  alu_result;
  logic       br_en;
  byte_enable mem_byte_enable;
  load_funct3 width;
  logic [1:0] addr_lo;

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  alu i_alu (
    .aluop (aluop),
    .a     (alu_in_1),
    .b     (alu_in_2),
    .f     (alu_result)
  );

  cmp i_cmp (
    .cmpop  (cmpop),
    .rs1    (rs1),
    .cmp_in (cmp_in),
    .br_en  (br_en)
  );

  // ------------------------------------------------------------
  // byte enable
  // ------------------------------------------------------------
  assign width   = instruction[14:12];
  assign addr_lo = alu_result[1:0];

  // lanes shifted out past lane 3 are dropped, which clips
  // a halfword at offset 3 and a word at offsets 1 to 3
  always_comb begin
    case (width)
      ld_lb, ld_lbu: mem_byte_enable = byte_enable'(4'b0001) << addr_lo;
      ld_lh, ld_lhu: mem_byte_enable = byte_enable'(4'b0011) << addr_lo;
      ld_lw:         mem_byte_enable = byte_enable'(4'b1111) << addr_lo;
      default:       mem_byte_enable = byte_enable'(4'b1111);
    endcase
  end

  // ------------------------------------------------------------
  // execute/memory register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_out              <= '0;
      instruction_out     <= '0;
      alu_out             <= '0;
      rs2_out             <= '0;
      br_en_out           <= 1'b0;
      mem_byte_enable_out <= '0;
      mem_read_out        <= 1'b0;
      mem_write_out       <= 1'b0;
      regfile_we_out      <= 1'b0;
    end else begin
      pc_out              <= pc;
      instruction_out     <= instruction;
      alu_out             <= alu_result;
      rs2_out             <= rs2;
      br_en_out           <= br_en;
      mem_byte_enable_out <= mem_byte_enable;
      mem_read_out        <= mem_read;
      mem_write_out       <= mem_write;
      regfile_we_out      <= regfile_we;
    end
  end

endmodule

// File: execute_top.sv
module execute_top (
  input  logic                     clk,
  input  logic                     rst,
  input  rv32i_types::rv32i_word   pc,
  input  rv32i_types::rv32i_word   instruction,
  input  rv32i_types::rv32i_word   rs1,
  input  rv32i_types::rv32i_word   rs2,
  input  rv32i_types::alumux1_sel  alumux1,
  input  rv32i_types::alumux2_sel  alumux2,
  input  rv32i_types::cmpmux_sel   cmpmux,
  input  rv32i_types::alu_op       aluop,
  input  rv32i_types::cmp_op       cmpop,
  input  logic                     mem_read,
  input  logic                     mem_write,
  input  logic                     regfile_we,
  output rv32i_types::rv32i_word   pc_out,
  output rv32i_types::rv32i_word   instruction_out,
  output rv32i_types::rv32i_word   alu_out,
  output rv32i_types::rv32i_word   rs2_out,
  output logic                     br_en_out,
  output rv32i_types::byte_enable  mem_byte_enable_out,
  output logic                     mem_read_out,
  output logic                     mem_write_out,
  output logic                     regfile_we_out
);

  import rv32i_types::*;

  // operands from the selection muxes
  rv32i_word alu_in_1;
  rv32i_word alu_in_2;
  rv32i_word cmp_in;

  operand_select i_operand_select (
    .instruction (instruction),
    .pc          (pc),
    .rs1         (rs1),
    .rs2         (rs2),
    .alumux1     (alumux1),
    .alumux2     (alumux2),
    .cmpmux      (cmpmux),
    .alu_in_1    (alu_in_1),
    .alu_in_2    (alu_in_2),
    .cmp_in      (cmp_in)
  );

  instruction_execute i_instruction_execute (
    .clk                 (clk),
    .rst                 (rst),
    .pc                  (pc),
    .instruction         (instruction),
    .alu_in_1            (alu_in_1),
    .alu_in_2            (alu_in_2),
    .rs1                 (rs1),
    .rs2                 (rs2),
    .cmp_in              (cmp_in),
    .aluop               (aluop),
    .cmpop               (cmpop),
    .mem_read            (mem_read),
    .mem_write           (mem_write),
    .regfile_we          (regfile_we),
    .pc_out              (pc_out),
    .instruction_out     (instruction_out),
    .alu_out             (alu_out),
    .rs2_out             (rs2_out),
    .br_en_out           (br_en_out),
    .mem_byte_enable_out (mem_byte_enable_out),
    .mem_read_out        (mem_read_out),
    .mem_write_out       (mem_write_out),
    .regfile_we_out      (regfile_we_out)
  );

endmodule

// File: execute_chk.sv
module execute_chk (
  input logic                    clk,
  input logic                    rst,
  input logic                    br_en_out,
  input rv32i_types::byte_enable mem_byte_enable_out,
  input logic                    mem_read_out,
  input logic                    mem_write_out,
  input logic                    regfile_we_out
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions so far
  int failures = 0;

  a_reset_clears: assert property (@(posedge clk) rst |=> !mem_read_out && !mem_write_out
      && !regfile_we_out && !br_en_out && mem_byte_enable_out == '0)
    else begin
      failures++;
      $error("control outputs not cleared by reset");
    end

  // a live register always enables at least one lane
  a_lanes_enabled: assert property (@(posedge clk) !rst |=> mem_byte_enable_out != '0)
    else begin
      failures++;
      $error("byte enable is zero outside reset");
    end

  a_read_write_excl: assert property (@(posedge clk) disable iff (rst)
      !(mem_read_out && mem_write_out))
    else begin
      failures++;
      $error("memory read and write requested together");
    end

endmodule

bind instruction_execute execute_chk i_execute_chk (
  .clk (clk), .rst (rst), .br_en_out (br_en_out),
  .mem_byte_enable_out (mem_byte_enable_out), .mem_read_out (mem_read_out),
  .mem_write_out (mem_write_out), .regfile_we_out (regfile_we_out)
);

// File: execute_monitor.sv
module execute_monitor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    exp_valid,
  input  int                      exp_test,
  input  rv32i_types::rv32i_word  exp_alu,
  input  logic                    exp_br,
  input  rv32i_types::byte_enable exp_be,
  input  rv32i_types::rv32i_word  in_pc,
  input  rv32i_types::rv32i_word  in_instruction,
  input  rv32i_types::rv32i_word  in_rs2,
  input  logic [2:0]              in_ctl,
  input  rv32i_types::rv32i_word  pc_out,
  input  rv32i_types::rv32i_word  instruction_out,
  input  rv32i_types::rv32i_word  alu_out,
  input  rv32i_types::rv32i_word  rs2_out,
  input  logic                    br_en_out,
  input  rv32i_types::byte_enable mem_byte_enable_out,
  input  logic                    mem_read_out,
  input  logic                    mem_write_out,
  input  logic                    regfile_we_out,
  output int                      error_count,
  output int                      pass_count,
  output int                      fail_count,
  output int                      checked_count
);

  timeunit 1ns;
  timeprecision 1ps;

  import rv32i_types::*;

  int q_test[$];
  rv32i_word q_alu[$], q_pc[$], q_ins[$], q_rs2[$];
  logic q_br[$];
  byte_enable q_be[$];
  logic [2:0] q_ctl[$];
  logic rst_seen = 1'b0;
  int errors = 0;
  int passes = 0;
  int fails = 0;
  int checked = 0;
  // test 0 is the reset phase
  int cur_test = 0;
  int cur_errors = 0;

  assign error_count = errors;
  assign pass_count = passes;
  assign fail_count = fails;
  assign checked_count = checked;

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      cur_errors++;
    end
  endtask

  // read, write, regfile enable in that bit order
  task automatic compare_controls(input logic [2:0] exp);
    check_word("mem_read_out", 32'(exp[2]), 32'(mem_read_out));
    check_word("mem_write_out", 32'(exp[1]), 32'(mem_write_out));
    check_word("regfile_we_out", 32'(exp[0]), 32'(regfile_we_out));
  endtask

  task report_test();
    if (cur_errors == 0) begin
      $display("test %0d passed", cur_test);
      passes++;
    end else begin
      $display("test %0d failed with %0d errors", cur_test, cur_errors);
      fails++;
    end
  endtask

  // inputs sampled by the DUT at this edge
  always @(posedge clk) begin
    rst_seen <= rst;
    if (exp_valid) begin
      q_test.push_back(exp_test);
      q_alu.push_back(exp_alu);
      q_br.push_back(exp_br);
      q_be.push_back(exp_be);
      q_pc.push_back(in_pc);
      q_ins.push_back(in_instruction);
      q_rs2.push_back(in_rs2);
      q_ctl.push_back(in_ctl);
    end
  end

  // ------------------------------------------------------------
  // compare mid-cycle, registered outputs are stable
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_seen) begin
      check_word("pc_out", 32'h0, pc_out);
      check_word("instruction_out", 32'h0, instruction_out);
      check_word("alu_out", 32'h0, alu_out);
      check_word("rs2_out", 32'h0, rs2_out);
      check_word("br_en_out", 32'h0, 32'(br_en_out));
      check_word("mem_byte_enable_out", 32'h0, 32'(mem_byte_enable_out));
      compare_controls(3'b000);
    end else if (q_alu.size() > 0) begin
      if (q_test[0] != cur_test) begin
        report_test();
        cur_test = q_test[0];
        cur_errors = 0;
      end
      void'(q_test.pop_front());
      check_word("alu_out", q_alu.pop_front(), alu_out);
      check_word("br_en_out", 32'(q_br.pop_front()), 32'(br_en_out));
      check_word("mem_byte_enable_out", 32'(q_be.pop_front()),
                 32'(mem_byte_enable_out));
      check_word("pc_out", q_pc.pop_front(), pc_out);
      check_word("instruction_out", q_ins.pop_front(), instruction_out);
      check_word("rs2_out", q_rs2.pop_front(), rs2_out);
      compare_controls(q_ctl.pop_front());
      checked++;
    end
  end

endmodule

// File: execute_tb.sv
`include "rv32i_settings.svh"

module execute_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rv32i_types::*;

  localparam int max_vectors = 128;
  localparam int max_lines = 512;

  logic clk;
  logic rst;
  rv32i_word pc, instruction, rs1, rs2;
  alumux1_sel alumux1;
  alumux2_sel alumux2;
  cmpmux_sel cmpmux;
  alu_op aluop;
  cmp_op cmpop;
  logic mem_read, mem_write, regfile_we;

  rv32i_word pc_out, instruction_out, alu_out, rs2_out;
  logic br_en_out;
  byte_enable mem_byte_enable_out;
  logic mem_read_out, mem_write_out, regfile_we_out;

  // expected values handed to the monitor
  logic exp_valid;
  int exp_test;
  rv32i_word exp_alu;
  logic exp_br;
  byte_enable exp_be;
  int error_count, pass_count, fail_count, checked_count;

  // vector table
  int v_test [max_vectors];
  rv32i_word v_pc [max_vectors];
  rv32i_word v_ins [max_vectors];
  rv32i_word v_rs1 [max_vectors];
  rv32i_word v_rs2 [max_vectors];
  logic [3:0] v_sel [max_vectors][3];
  logic [2:0] v_op [max_vectors][2];
  logic [2:0] v_ctl [max_vectors];
  rv32i_word v_alu [max_vectors];
  logic v_br [max_vectors];
  byte_enable v_be [max_vectors];
  int nvec;
  logic load_ok;
  logic timed_out;

  execute_top i_execute_top (.*);

  execute_monitor i_monitor (
    .clk (clk), .rst (rst), .exp_valid (exp_valid), .exp_test (exp_test),
    .exp_alu (exp_alu), .exp_br (exp_br), .exp_be (exp_be), .in_pc (pc),
    .in_instruction (instruction), .in_rs2 (rs2),
    .in_ctl ({mem_read, mem_write, regfile_we}),
    .pc_out (pc_out), .instruction_out (instruction_out), .alu_out (alu_out),
    .rs2_out (rs2_out), .br_en_out (br_en_out),
    .mem_byte_enable_out (mem_byte_enable_out), .mem_read_out (mem_read_out),
    .mem_write_out (mem_write_out), .regfile_we_out (regfile_we_out),
    .error_count (error_count), .pass_count (pass_count),
    .fail_count (fail_count), .checked_count (checked_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // vector file, lines starting with # are skipped
  // ------------------------------------------------------------
  task automatic read_vectors();
    int fd, n, lines, t;
    string line;
    logic [`RV32I_XLEN-1:0] a_pc, a_ins, a_rs1, a_rs2, a_alu;
    logic [3:0] m1, m2, mc, ao, co, rd, wr, we, br, be;
    nvec = 0;
    lines = 0;
    load_ok = 1'b1;
    fd = $fopen("execute_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file execute_input.txt");
      load_ok = 1'b0;
      return;
    end
    while (!$feof(fd) && lines < max_lines && nvec < max_vectors) begin
      lines++;
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  t, a_pc, a_ins, a_rs1, a_rs2, m1, m2, mc, ao, co, rd, wr, we,
                  a_alu, br, be);
      if (n != 16) begin
        $display("vector file line %0d has %0d fields instead of 16", lines, n);
        load_ok = 1'b0;
        continue;
      end
      v_test[nvec] = t;
      v_pc[nvec] = a_pc;
      v_ins[nvec] = a_ins;
      v_rs1[nvec] = a_rs1;
      v_rs2[nvec] = a_rs2;
      v_sel[nvec] = '{m1, m2, mc};
      v_op[nvec] = '{ao[2:0], co[2:0]};
      v_ctl[nvec] = {rd[0], wr[0], we[0]};
      v_alu[nvec] = a_alu;
      v_br[nvec] = br[0];
      v_be[nvec] = be;
      nvec++;
    end
    $fclose(fd);
    if (nvec == 0) begin
      $display("the vector file ended before any vector was read");
      load_ok = 1'b0;
    end
  endtask

  task automatic drive_vector(input int k);
    pc = v_pc[k];
    instruction = v_ins[k];
    rs1 = v_rs1[k];
    rs2 = v_rs2[k];
    alumux1 = v_sel[k][0][0];
    alumux2 = v_sel[k][1][2:0];
    cmpmux = v_sel[k][2][0];
    aluop = v_op[k][0];
    cmpop = v_op[k][1];
    {mem_read, mem_write, regfile_we} = v_ctl[k];
    exp_valid = 1'b1;
    exp_test = v_test[k];
    exp_alu = v_alu[k];
    exp_br = v_br[k];
    exp_be = v_be[k];
  endtask

  initial begin
    int wait_cycles;
    int assert_failures;
    rst = 1'b1;
    pc = '0;
    instruction = '0;
    rs1 = '0;
    rs2 = '0;
    alumux1 = sel1_rs1;
    alumux2 = sel2_i_imm;
    cmpmux = selc_rs2;
    aluop = alu_add;
    cmpop = cmp_beq;
    mem_read = 1'b0;
    mem_write = 1'b0;
    regfile_we = 1'b0;
    exp_valid = 1'b0;
    exp_test = 0;
    exp_alu = '0;
    exp_br = 1'b0;
    exp_be = '0;
    timed_out = 1'b0;
    read_vectors();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // back-to-back, one vector per clock
    if (load_ok) begin
      for (int k = 0; k < nvec; k++) begin
        drive_vector(k);
        @(posedge clk);
        #1;
      end
    end
    exp_valid = 1'b0;
    wait_cycles = 0;
    while (load_ok && checked_count < nvec && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (load_ok && checked_count < nvec) begin
      $display("timeout: only %0d of %0d vectors were checked", checked_count, nvec);
      timed_out = 1'b1;
    end
    i_monitor.report_test();
    #1;
    assert_failures = i_execute_top.i_instruction_execute.i_execute_chk.failures;
    $display("tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             pass_count, fail_count, error_count, assert_failures);
    if (load_ok && !timed_out && error_count == 0 && fail_count == 0
        && assert_failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: execute_input.txt
# test pc instr rs1 rs2 alumux1 alumux2 cmpmux aluop cmpop mem_read mem_write regfile_we
# then expected alu_out br_en_out mem_byte_enable_out; test is decimal, the rest hex
1 00001000 00003033 12345678 11111111 0 5 0 0 2 0 0 1 23456789 0 f
1 00001000 00003033 00000005 00000007 0 5 0 3 2 0 0 1 fffffffe 0 f
1 00001000 00003033 f0f0f0f0 ff00ff00 0 5 0 4 2 0 0 1 0ff00ff0 0 f
1 00001000 00003033 f0f0f0f0 0f000f00 0 5 0 6 2 0 0 1 fff0fff0 0 f
1 00001000 00003033 f0f0f0f0 ff00ff00 0 5 0 7 2 0 0 1 f000f000 0 f
1 00001000 00003033 00000001 00000024 0 5 0 1 2 0 0 1 00000010 0 f
1 00001000 00003033 80000000 0000003f 0 5 0 5 2 0 0 1 00000001 0 f
1 00001000 00003033 f0000000 00000024 0 5 0 2 2 0 0 1 ff000000 0 f
2 00001000 fff03013 00000010 00000000 0 0 0 0 2 0 0 1 0000000f 0 f
2 00001000 80003013 00001000 00000000 0 0 0 0 2 0 0 1 00000800 0 f
2 00001000 02503013 00000003 00000000 0 0 0 1 2 0 0 1 00000060 0 f
2 00001000 41f03013 80000000 00000000 0 0 0 2 2 0 0 1 ffffffff 0 f
2 00001000 80003013 00000012 00000000 0 0 0 6 2 0 0 1 fffff812 0 f
3 00002000 00003063 80000000 00000001 0 5 0 0 0 0 0 0 80000001 0 f
3 00002000 00003063 80000000 00000001 0 5 0 0 1 0 0 0 80000001 1 f
3 00002000 00003063 80000000 00000001 0 5 0 0 4 0 0 0 80000001 1 f
3 00002000 00003063 80000000 00000001 0 5 0 0 5 0 0 0 80000001 0 f
3 00002000 00003063 80000000 00000001 0 5 0 0 6 0 0 0 80000001 0 f
3 00002000 00003063 80000000 00000001 0 5 0 0 7 0 0 0 80000001 1 f
3 00002000 fff03013 80000000 00000000 0 5 1 0 4 0 0 1 80000000 1 f
3 00002000 fff03013 00000005 00000000 0 5 1 0 6 0 0 1 00000005 1 f
4 00003000 fe002e23 00001008 00000000 0 3 0 0 2 0 1 0 00001004 0 f
4 00000100 00000463 00000000 00000000 1 2 0 0 0 0 0 0 00000108 1 1
4 00000200 fe001ee3 00000001 00000002 1 2 0 0 1 0 0 0 000001fc 1 3
4 00003000 12345037 00000000 00000000 0 1 0 0 2 0 0 1 12345000 0 3
4 00001004 00001017 00000000 00000000 1 1 0 0 2 0 0 1 00002004 0 3
4 00000400 0100006f 00000000 00000000 1 4 0 0 2 0 0 1 00000410 0 1
4 00000800 fffff06f 00000000 00000000 1 4 0 0 2 0 0 1 000007fe 0 f
5 00004000 00300003 00002000 00000000 0 0 0 0 2 1 0 1 00002003 0 8
5 00004000 00104003 00002000 00000000 0 0 0 0 2 1 0 1 00002001 0 2
5 00004000 00101003 00002000 00000000 0 0 0 0 2 1 0 1 00002001 0 6
5 00004000 00305003 00002000 00000000 0 0 0 0 2 1 0 1 00002003 0 8
5 00004000 00002003 00002000 00000000 0 0 0 0 2 1 0 1 00002000 0 f
5 00004000 00202003 00002000 00000000 0 0 0 0 2 1 0 1 00002002 0 c
5 00004000 00306003 00002000 00000000 0 0 0 0 2 1 0 1 00002003 0 f
5 00004000 000000a3 00002000 11223344 0 3 0 0 2 0 1 0 00002001 0 2
5 00004000 000011a3 00002000 11223344 0 3 0 0 2 0 1 0 00002003 0 8
5 00004000 00002123 00002000 11223344 0 3 0 0 2 0 1 0 00002002 0 c
6 00000010 00003033 00000001 00000001 0 5 0 0 2 0 0 1 00000002 0 f
6 00000014 00003033 0000000a 00000005 0 5 0 3 2 1 0 1 00000005 0 f
6 00000018 00003033 deadbeef 00000000 0 5 0 4 2 0 1 0 deadbeef 0 f
6 0000001c 00003033 00000000 cafef00d 0 5 0 6 2 0 0 0 cafef00d 0 f

// File: list.f
+incdir+.
rv32i_types.sv
alu.sv
cmp.sv
operand_select.sv
instruction_execute.sv
execute_top.sv
execute_chk.sv
execute_monitor.sv
execute_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := execute_tb
FILELIST  := list.f
FLAGS     := --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
